// ==== source/mtrap_config.svh ====
`ifndef MTRAP_CONFIG_SVH
`define MTRAP_CONFIG_SVH

// Data width of the machine CSRs.
`define MTRAP_XLEN          32

// External interrupt lines, as numbered in mip and mie.
`define MTRAP_IRQ_LO        16
`define MTRAP_IRQ_HI        31

// Cycles mstatus.MIE must hold before an interrupt is taken, at least 2.
`define MTRAP_MIE_SETTLE    2

// AXI byte address width. CSR number sits in bits 13 to 2.
`define MTRAP_AXI_AW        14

// Machine CSR numbers.
`define MTRAP_CSR_MSTATUS   12'h300
`define MTRAP_CSR_MISA      12'h301
`define MTRAP_CSR_MEDELEG   12'h302
`define MTRAP_CSR_MIDELEG   12'h303
`define MTRAP_CSR_MIE       12'h304
`define MTRAP_CSR_MTVEC     12'h305
`define MTRAP_CSR_MSTATUSH  12'h310
`define MTRAP_CSR_MSCRATCH  12'h340
`define MTRAP_CSR_MEPC      12'h341
`define MTRAP_CSR_MCAUSE    12'h342
`define MTRAP_CSR_MTVAL     12'h343
`define MTRAP_CSR_MIP       12'h344
`define MTRAP_CSR_MVENDORID 12'hf11
`define MTRAP_CSR_MARCHID   12'hf12
`define MTRAP_CSR_MIMPID    12'hf13
`define MTRAP_CSR_MHARTID   12'hf14
`define MTRAP_CSR_MCONFIGPTR 12'hf15

// RV32IM, MXL of 1 with the I and M bits.
`define MTRAP_MISA_VAL      32'h4000_1100

// AXI response codes.
`define MTRAP_RESP_OKAY     2'd0
`define MTRAP_RESP_SLVERR   2'd2

`endif

// ==== source/mtrap_pkg.sv ====
`include "mtrap_config.svh"

package mtrap_pkg;

    // One machine word.
    typedef logic [`MTRAP_XLEN-1:0] xword_t;

    // CSR number as carried on the bank port.
    typedef logic [11:0] csr_addr_t;

    // Trap or interrupt number, as stored in mcause.
    typedef logic [$clog2(`MTRAP_XLEN)-1:0] cause_t;

    // AXI response field.
    typedef logic [1:0] axi_resp_t;

    // Event taken by the trap unit in one cycle.
    typedef enum logic [1:0] {
        kind_none,
        kind_trap,
        kind_irq,
        kind_ret
    } trap_kind_e;

endpackage

// ==== source/csr_axil_slave.sv ====
`timescale 1ns/1ps
`include "mtrap_config.svh"

module csr_axil_slave import mtrap_pkg::*; (
    input  logic                       clk,
    input  logic                       rst,

    // Write address and data.
    input  logic                       awvalid,
    output logic                       awready,
    input  logic [`MTRAP_AXI_AW-1:0]   awaddr,
    input  logic                       wvalid,
    output logic                       wready,
    input  xword_t                     wdata,
    input  logic [`MTRAP_XLEN/8-1:0]   wstrb,

    // Write response.
    output logic                       bvalid,
    input  logic                       bready,
    output axi_resp_t                  bresp,

    // Read address and data.
    input  logic                       arvalid,
    output logic                       arready,
    input  logic [`MTRAP_AXI_AW-1:0]   araddr,
    output logic                       rvalid,
    input  logic                       rready,
    output xword_t                     rdata,
    output axi_resp_t                  rresp,

    // CSR bank port.
    output csr_addr_t                  csr_addr,
    output logic                       csr_we,
    output xword_t                     csr_wdata,
    input  xword_t                     csr_rdata,
    input  logic                       csr_exists,
    input  logic                       csr_rdonly
);
    // Write accepted this cycle.
    logic wr_go;
    // Read accepted this cycle.
    logic rd_go;
    // Target may be written.
    logic wr_ok;

    // Address and data must both be present, and the B slot free.
    assign wr_go = awvalid && wvalid && !bvalid;
    // Read waits for a free R slot and yields to a write.
    assign rd_go = arvalid && !rvalid && !wr_go;

    assign awready = wr_go;
    assign wready  = wr_go;
    assign arready = rd_go;

    // One shared bank port with the write first.
    assign csr_addr = wr_go ? awaddr[`MTRAP_AXI_AW-1:2] : araddr[`MTRAP_AXI_AW-1:2];

    // Partial strobes still write the whole word; wstrb is not decoded.
    assign csr_wdata = wdata;
    assign wr_ok     = csr_exists && !csr_rdonly;
    assign csr_we    = wr_go && wr_ok;

    // Write response handshake.
    always_ff @(posedge clk) begin
        if (rst) begin
            bvalid <= 1'b0;
        end else if (wr_go) begin
            bvalid <= 1'b1;
        end else if (bready) begin
            bvalid <= 1'b0;
        end
    end

    // Held until bready, since no new write gets in meanwhile.
    always_ff @(posedge clk) begin
        if (wr_go) begin
            bresp <= wr_ok ? `MTRAP_RESP_OKAY : `MTRAP_RESP_SLVERR;
        end
    end

    // Read response handshake.
    always_ff @(posedge clk) begin
        if (rst) begin
            rvalid <= 1'b0;
        end else if (rd_go) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    // Bank already returns zero for an unknown CSR.
    always_ff @(posedge clk) begin
        if (rd_go) begin
            rdata <= csr_rdata;
            rresp <= csr_exists ? `MTRAP_RESP_OKAY : `MTRAP_RESP_SLVERR;
        end
    end

endmodule

// ==== source/irq_prioritizer.sv ====
`timescale 1ns/1ps
`include "mtrap_config.svh"

module irq_prioritizer import mtrap_pkg::*; (
    input  logic                                 clk,
    input  logic                                 rst,
    // External lines, numbered as in mip.
    input  logic [`MTRAP_IRQ_HI:`MTRAP_IRQ_LO]   irq,
    input  xword_t                               mie,
    input  logic                                 mstatus_mie,
    output logic                                 irq_pending,
    output cause_t                               irq_cause,
    // Latched lines, read back through mip.
    output xword_t                               irq_ip
);
    // Past values of mstatus.MIE, newest in bit 0.
    logic [`MTRAP_MIE_SETTLE-1:0] mie_hist;
    // Pending and enabled lines.
    xword_t masked;

    // Lines are registered once; the low causes are never external.
    always_ff @(posedge clk) begin
        if (rst) begin
            irq_ip <= '0;
        end else begin
            irq_ip <= {irq, {`MTRAP_IRQ_LO{1'b0}}};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mie_hist <= '0;
        end else begin
            mie_hist <= {mie_hist[`MTRAP_MIE_SETTLE-2:0], mstatus_mie};
        end
    end

    assign masked = irq_ip & mie;

    // Scan from the top so the lowest set line wins.
    always_comb begin
        irq_cause = '0;
        for (int i = `MTRAP_IRQ_HI; i >= `MTRAP_IRQ_LO; i--) begin
            if (masked[i]) begin
                irq_cause = cause_t'(i);
            end
        end
    end

    // Enable must have settled and still be set now.
    assign irq_pending = (|masked) && (&mie_hist) && mstatus_mie;

endmodule

// ==== source/trap_dispatch.sv ====
`timescale 1ns/1ps

module trap_dispatch import mtrap_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       irq_pending,
    input  cause_t     irq_cause,
    // Instruction boundary.
    input  logic       retire_valid,
    input  xword_t     retire_pc,
    // Synchronous trap.
    input  logic       trap_valid,
    input  cause_t     trap_cause,
    input  xword_t     trap_epc,
    input  logic       mret_valid,
    // Vector and return address from the bank.
    input  xword_t     mtvec,
    input  xword_t     mepc,
    output trap_kind_e event_kind,
    output cause_t     event_cause,
    output xword_t     event_epc,
    output logic       redirect_valid,
    output xword_t     redirect_pc
);
    // Interrupt, then trap, then MRET.
    always_comb begin
        event_kind  = kind_none;
        event_cause = '0;
        event_epc   = '0;
        if (irq_pending && retire_valid) begin
            // Interrupt lands at the retiring instruction.
            event_kind  = kind_irq;
            event_cause = irq_cause;
            event_epc   = retire_pc;
        end else if (trap_valid) begin
            event_kind  = kind_trap;
            event_cause = trap_cause;
            event_epc   = trap_epc;
        end else if (mret_valid) begin
            event_kind  = kind_ret;
        end
    end

    // One-cycle pulse after any accepted event.
    always_ff @(posedge clk) begin
        if (rst) begin
            redirect_valid <= 1'b0;
        end else begin
            redirect_valid <= (event_kind != kind_none);
        end
    end

    // Bank values are still the old ones at this edge.
    always_ff @(posedge clk) begin
        if (event_kind != kind_none) begin
            redirect_pc <= (event_kind == kind_ret) ? mepc : mtvec;
        end
    end

endmodule

// ==== source/csr_bank.sv ====
`timescale 1ns/1ps
`include "mtrap_config.svh"

module csr_bank import mtrap_pkg::*; #(
    // Value read from mhartid.
    parameter xword_t hartid = '0
) (
    input  logic       clk,
    input  logic       rst,
    // Access port.
    input  csr_addr_t  csr_addr,
    input  logic       csr_we,
    input  xword_t     csr_wdata,
    // Event taken this cycle.
    input  trap_kind_e event_kind,
    input  cause_t     event_cause,
    input  xword_t     event_epc,
    input  xword_t     irq_ip,
    output xword_t     csr_rdata,
    output logic       csr_exists,
    output logic       csr_rdonly,
    output xword_t     mie,
    output logic       mstatus_mie,
    output xword_t     mtvec,
    output xword_t     mepc
);
    // mstatus.MPIE.
    logic   mpie;
    // mstatus.MIE.
    logic   mie_bit;
    xword_t mscratch;
    // mcause interrupt flag.
    logic   mcause_int;
    // mcause number.
    cause_t mcause_no;

    assign mstatus_mie = mie_bit;

    // Read decode.
    always_comb begin
        csr_rdata  = '0;
        csr_exists = 1'b1;
        csr_rdonly = 1'b0;
        case (csr_addr)
            `MTRAP_CSR_MSTATUS: begin
                csr_rdata[7] = mpie;
                csr_rdata[3] = mie_bit;
            end
            `MTRAP_CSR_MISA:     csr_rdata = `MTRAP_MISA_VAL;
            `MTRAP_CSR_MIE:      csr_rdata = mie;
            `MTRAP_CSR_MTVEC:    csr_rdata = mtvec;
            // Only enabled lines show as pending.
            `MTRAP_CSR_MIP:      csr_rdata = irq_ip & mie;
            `MTRAP_CSR_MSCRATCH: csr_rdata = mscratch;
            `MTRAP_CSR_MEPC:     csr_rdata = mepc;
            `MTRAP_CSR_MCAUSE: begin
                csr_rdata = {mcause_int, {(`MTRAP_XLEN - 1 - $bits(cause_t)){1'b0}}, mcause_no};
            end
            // No delegation, no mstatush fields, no trap value.
            `MTRAP_CSR_MEDELEG, `MTRAP_CSR_MIDELEG, `MTRAP_CSR_MSTATUSH, `MTRAP_CSR_MTVAL: begin
                csr_rdata = '0;
            end
            // Identification, all zero.
            `MTRAP_CSR_MVENDORID, `MTRAP_CSR_MARCHID, `MTRAP_CSR_MIMPID,
            `MTRAP_CSR_MCONFIGPTR: begin
                csr_rdonly = 1'b1;
            end
            `MTRAP_CSR_MHARTID: begin
                csr_rdata  = hartid;
                csr_rdonly = 1'b1;
            end
            default: csr_exists = 1'b0;
        endcase
    end

    // Update order is MRET, then trap or interrupt, then bus write.
    always_ff @(posedge clk) begin
        if (rst) begin
            mpie       <= 1'b0;
            mie_bit    <= 1'b0;
            mie        <= '0;
            mtvec      <= '0;
            mscratch   <= '0;
            mepc       <= '0;
            mcause_int <= 1'b0;
            mcause_no  <= '0;
        end else if (event_kind == kind_ret) begin
            mie_bit <= mpie;
        end else if (event_kind == kind_trap || event_kind == kind_irq) begin
            // Save enable and disable further interrupts.
            mpie       <= mie_bit;
            mie_bit    <= 1'b0;
            mepc       <= {event_epc[`MTRAP_XLEN-1:1], 1'b0};
            mcause_int <= (event_kind == kind_irq);
            mcause_no  <= event_cause;
        end else if (csr_we) begin
            case (csr_addr)
                `MTRAP_CSR_MSTATUS: begin
                    mpie    <= csr_wdata[7];
                    mie_bit <= csr_wdata[3];
                end
                `MTRAP_CSR_MIE:      mie <= csr_wdata;
                // Direct mode only.
                `MTRAP_CSR_MTVEC:    mtvec <= {csr_wdata[`MTRAP_XLEN-1:2], 2'b00};
                `MTRAP_CSR_MSCRATCH: mscratch <= csr_wdata;
                `MTRAP_CSR_MEPC:     mepc <= {csr_wdata[`MTRAP_XLEN-1:1], 1'b0};
                `MTRAP_CSR_MCAUSE: begin
                    mcause_int <= csr_wdata[`MTRAP_XLEN-1];
                    mcause_no  <= csr_wdata[$bits(cause_t)-1:0];
                end
                // other CSRs ignore writes
                default: ;
            endcase
        end
    end

endmodule

// ==== source/mtrap_unit.sv ====
`timescale 1ns/1ps
`include "mtrap_config.svh"

module mtrap_unit import mtrap_pkg::*; #(
    // Value read from mhartid.
    parameter xword_t hartid = '0
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic [`MTRAP_IRQ_HI:`MTRAP_IRQ_LO]   irq,
    // Events from the core.
    input  logic                                 retire_valid,
    input  xword_t                               retire_pc,
    input  logic                                 trap_valid,
    input  cause_t                               trap_cause,
    input  xword_t                               trap_epc,
    input  logic                                 mret_valid,
    output logic                                 redirect_valid,
    output xword_t                               redirect_pc,
    // AXI4-Lite CSR access.
    input  logic                                 awvalid,
    output logic                                 awready,
    input  logic [`MTRAP_AXI_AW-1:0]             awaddr,
    input  logic                                 wvalid,
    output logic                                 wready,
    input  xword_t                               wdata,
    input  logic [`MTRAP_XLEN/8-1:0]             wstrb,
    output logic                                 bvalid,
    input  logic                                 bready,
    output axi_resp_t                            bresp,
    input  logic                                 arvalid,
    output logic                                 arready,
    input  logic [`MTRAP_AXI_AW-1:0]             araddr,
    output logic                                 rvalid,
    input  logic                                 rready,
    output xword_t                               rdata,
    output axi_resp_t                            rresp
);
    // Bus side of the bank.
    csr_addr_t  csr_addr;
    logic       csr_we;
    xword_t     csr_wdata;
    xword_t     csr_rdata;
    logic       csr_exists;
    logic       csr_rdonly;
    // Interrupt state.
    xword_t     mie;
    logic       mstatus_mie;
    xword_t     irq_ip;
    logic       irq_pending;
    cause_t     irq_cause;
    // Event path.
    trap_kind_e event_kind;
    cause_t     event_cause;
    xword_t     event_epc;
    xword_t     mtvec;
    xword_t     mepc;

    csr_axil_slave i_axil (.*);

    irq_prioritizer i_irq (.*);

    trap_dispatch i_dispatch (.*);

    csr_bank #(.hartid(hartid)) i_bank (.*);

endmodule

// ==== bench/mtrap_unit_tb.sv ====
`timescale 1ns/1ps
`include "mtrap_config.svh"

module mtrap_unit_tb import mtrap_pkg::*; ();

    // Clock and reset.
    logic clk = 1'b0;
    logic rst;

    // Core side of the DUT.
    logic [`MTRAP_IRQ_HI:`MTRAP_IRQ_LO] irq;
    logic      retire_valid;
    xword_t    retire_pc;
    logic      trap_valid;
    cause_t    trap_cause;
    xword_t    trap_epc;
    logic      mret_valid;
    logic      redirect_valid;
    xword_t    redirect_pc;

    // AXI4-Lite side of the DUT.
    logic                     awvalid;
    logic                     awready;
    logic [`MTRAP_AXI_AW-1:0] awaddr;
    logic                     wvalid;
    logic                     wready;
    xword_t                   wdata;
    logic [`MTRAP_XLEN/8-1:0] wstrb;
    logic                     bvalid;
    logic                     bready;
    axi_resp_t                bresp;
    logic                     arvalid;
    logic                     arready;
    logic [`MTRAP_AXI_AW-1:0] araddr;
    logic                     rvalid;
    logic                     rready;
    xword_t                   rdata;
    axi_resp_t                rresp;

    // CSR number 0x7c0 is not implemented.
    localparam logic [`MTRAP_AXI_AW-1:0] unmapped_addr = 14'h1f00;

    // Trace text, one entry per file line.
    string  lines[$];
    int     cycle_count = 0;
    // Zero until the trace is loaded.
    int     cycle_limit = 0;
    int     fail_count = 0;
    integer seed = 32'hc6e7a693;

    mtrap_unit #(.hartid(32'h0000_0003)) i_dut (.*);

    always #20 clk = ~clk;

    // Run limit of 40 cycles per trace line.
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit != 0 && cycle_count > cycle_limit) begin
            $display("Timeout: the trace did not finish within %0d cycles.", cycle_limit);
            $display("=== FAIL ===");
            $fatal(1, "Simulation ran too long.");
        end
    end

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (expected !== actual) begin
            fail_count++;
            $display("Mismatch %s: expected %08h, actual %08h", name, expected, actual);
            $display("=== FAIL ===");
            $fatal(1, "Value check failed.");
        end
    endtask

    // Entered and left 1 ns after a rising edge.
    task automatic bus_write(input string name, input logic [31:0] addr,
                             input logic [31:0] data, input logic [31:0] resp);
        awaddr  = addr[`MTRAP_AXI_AW-1:0];
        wdata   = data;
        wstrb   = '1;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = 1'b1;
        @(negedge clk);
        while (!awready) @(negedge clk);
        compare_value($sformatf("%s wready", name), 32'd1, 32'(wready));
        // Address and data taken at this edge.
        @(posedge clk);
        #1;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        @(negedge clk);
        while (!bvalid) @(negedge clk);
        compare_value($sformatf("%s bresp", name), resp, 32'(bresp));
        @(posedge clk);
        #1;
        bready = 1'b0;
    endtask

    task automatic bus_read(input string name, input logic [31:0] addr,
                            input logic [31:0] data, input logic [31:0] resp);
        araddr  = addr[`MTRAP_AXI_AW-1:0];
        arvalid = 1'b1;
        rready  = 1'b1;
        @(negedge clk);
        while (!arready) @(negedge clk);
        @(posedge clk);
        #1;
        arvalid = 1'b0;
        @(negedge clk);
        while (!rvalid) @(negedge clk);
        compare_value($sformatf("%s rdata", name), data, rdata);
        compare_value($sformatf("%s rresp", name), resp, 32'(rresp));
        @(posedge clk);
        #1;
        rready = 1'b0;
    endtask

    // Called just after the event edge; pulse is due in the next cycle only.
    task automatic expect_redirect(input string name, input logic taken,
                                   input logic [31:0] target);
        @(negedge clk);
        if (taken) begin
            compare_value($sformatf("%s redirect_valid", name), 32'd1, 32'(redirect_valid));
            compare_value($sformatf("%s redirect_pc", name), target, redirect_pc);
            @(negedge clk);
            compare_value($sformatf("%s pulse end", name), 32'd0, 32'(redirect_valid));
        end else begin
            repeat (10) begin
                compare_value($sformatf("%s no redirect", name), 32'd0, 32'(redirect_valid));
                @(negedge clk);
            end
        end
        @(posedge clk);
        #1;
    endtask

    task automatic raise_interrupt(input string name, input logic [31:0] mask,
                                   input logic [31:0] pc, input logic [31:0] taken,
                                   input logic [31:0] target);
        irq = mask[15:0];
        // Lines reach mip one edge later.
        @(posedge clk);
        #1;
        retire_valid = 1'b1;
        retire_pc    = pc;
        @(posedge clk);
        #1;
        retire_valid = 1'b0;
        expect_redirect(name, taken != 0, target);
    endtask

    task automatic raise_trap(input string name, input logic [31:0] cause,
                              input logic [31:0] epc, input logic [31:0] target);
        trap_valid = 1'b1;
        trap_cause = cause[$bits(cause_t)-1:0];
        trap_epc   = epc;
        @(posedge clk);
        #1;
        trap_valid = 1'b0;
        expect_redirect(name, 1'b1, target);
    endtask

    task automatic raise_mret(input string name, input logic [31:0] target);
        mret_valid = 1'b1;
        @(posedge clk);
        #1;
        mret_valid = 1'b0;
        expect_redirect(name, 1'b1, target);
    endtask

    // Write then read with the response held back.
    // The second request goes to an unmapped CSR and waits meanwhile.
    task automatic backpressure_check(input string name, input logic [31:0] addr,
                                      input logic [31:0] data, input logic [31:0] readback);
        int        stall;
        axi_resp_t held_resp;
        xword_t    held_data;
        stall   = 2 + ($random(seed) & 7);
        awaddr  = addr[`MTRAP_AXI_AW-1:0];
        wdata   = data;
        wstrb   = '1;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = 1'b0;
        @(negedge clk);
        while (!awready) @(negedge clk);
        @(posedge clk);
        #1;
        // Request stays up as the second write.
        awaddr = unmapped_addr;
        @(negedge clk);
        compare_value($sformatf("%s bvalid", name), 32'd1, 32'(bvalid));
        held_resp = bresp;
        compare_value($sformatf("%s bresp", name), 32'd0, 32'(held_resp));
        for (int i = 0; i < stall; i++) begin
            compare_value($sformatf("%s bvalid held", name), 32'd1, 32'(bvalid));
            compare_value($sformatf("%s bresp stable", name), 32'(held_resp), 32'(bresp));
            compare_value($sformatf("%s second write", name), 32'd0, 32'(awready));
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        bready = 1'b1;
        @(negedge clk);
        while (!awready) @(negedge clk);
        @(posedge clk);
        #1;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        @(negedge clk);
        while (!bvalid) @(negedge clk);
        compare_value($sformatf("%s second bresp", name), 32'd2, 32'(bresp));
        @(posedge clk);
        #1;
        bready = 1'b0;
        // Same pattern on the read side.
        araddr  = addr[`MTRAP_AXI_AW-1:0];
        arvalid = 1'b1;
        rready  = 1'b0;
        @(negedge clk);
        while (!arready) @(negedge clk);
        @(posedge clk);
        #1;
        araddr = unmapped_addr;
        @(negedge clk);
        compare_value($sformatf("%s rvalid", name), 32'd1, 32'(rvalid));
        held_data = rdata;
        compare_value($sformatf("%s rdata", name), readback, held_data);
        for (int i = 0; i < stall; i++) begin
            compare_value($sformatf("%s rvalid held", name), 32'd1, 32'(rvalid));
            compare_value($sformatf("%s rdata stable", name), held_data, rdata);
            compare_value($sformatf("%s second read", name), 32'd0, 32'(arready));
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        rready = 1'b1;
        @(negedge clk);
        while (!arready) @(negedge clk);
        @(posedge clk);
        #1;
        arvalid = 1'b0;
        @(negedge clk);
        while (!rvalid) @(negedge clk);
        compare_value($sformatf("%s second rdata", name), 32'd0, rdata);
        compare_value($sformatf("%s second rresp", name), 32'd2, 32'(rresp));
        @(posedge clk);
        #1;
        rready = 1'b0;
    endtask

    task automatic load_trace();
        int    fd;
        string line;
        fd = $fopen("bench/mtrap_trace.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the trace file bench/mtrap_trace.txt.");
            $display("=== FAIL ===");
            $fatal(1, "Missing trace file.");
        end
        while ($fgets(line, fd) != 0) lines.push_back(line);
        $fclose(fd);
    endtask

    task automatic run_trace();
        string       line;
        string       name;
        byte         op;
        logic [31:0] f0;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;
        int          n;
        for (int idx = 0; idx < lines.size(); idx++) begin
            line = lines[idx];
            if (line.len() < 2) continue;
            op = line.getc(0);
            // Comments and blank lines.
            if (op == "#" || op == " " || op == "\r") continue;
            f0 = '0;
            f1 = '0;
            f2 = '0;
            f3 = '0;
            n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %h", f0, f1, f2, f3);
            name = $sformatf("line %0d %c %04h", idx + 1, op, f0);
            case (op)
                "W": bus_write(name, f0, f1, f2);
                "R": bus_read(name, f0, f1, f2);
                "B": backpressure_check(name, f0, f1, f2);
                "I": raise_interrupt(name, f0, f1, f2, f3);
                "T": raise_trap(name, f0, f1, f2);
                "M": raise_mret(name, f0);
                default: begin
                    $display("Unknown operation '%c' on trace line %0d.", op, idx + 1);
                    $display("=== FAIL ===");
                    $fatal(1, "Bad trace line.");
                end
            endcase
        end
    endtask

    initial begin
        rst          = 1'b1;
        irq          = '0;
        retire_valid = 1'b0;
        retire_pc    = '0;
        trap_valid   = 1'b0;
        trap_cause   = '0;
        trap_epc     = '0;
        mret_valid   = 1'b0;
        awvalid      = 1'b0;
        awaddr       = '0;
        wvalid       = 1'b0;
        wdata        = '0;
        wstrb        = '0;
        bready       = 1'b0;
        arvalid      = 1'b0;
        araddr       = '0;
        rready       = 1'b0;
        load_trace();
        cycle_limit = lines.size() * 40;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        run_trace();
        repeat (2) @(posedge clk);
        if (fail_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== bench/mtrap_trace.txt ====
# W addr data bresp | R addr data rresp | B addr data readback (hex, addr = CSR number * 4)
# I irqmask retirepc taken target | T cause epc target | M target
# Constant and unknown CSRs.
R 0c04 40001100 0
R 3c50 00000003 0
R 1f00 00000000 2
W 3c44 12345678 2
R 3c44 00000000 0
# Writable CSRs.
W 0d00 a5a5f00d 0
R 0d00 a5a5f00d 0
W 0c10 ffff0000 0
R 0c10 ffff0000 0
W 0c14 00001003 0
R 0c14 00001000 0
# Synchronous trap with MIE set, then MRET.
W 0c00 00000008 0
T 0b 00000480 00001000
R 0d08 0000000b 0
R 0d04 00000480 0
R 0c00 00000080 0
M 00000480
R 0c00 00000088 0
# Lines 18 20 21 25 27 raised, lines 21 and up enabled.
W 0c10 ffe00000 0
W 0c14 00002000 0
I 0a34 00000500 1 00002000
R 0d08 80000015 0
R 0d10 0a200000 0
R 0d04 00000500 0
R 0c00 00000080 0
# MIE now clear, so no interrupt.
I 0a34 00000600 0 00000000
M 00000500
R 0c00 00000088 0
# Back-pressure on both response channels.
B 0d00 13572468 13572468
B 0c14 0000abcf 0000abcc

// ==== flist.f ====
+incdir+source
source/mtrap_pkg.sv
source/csr_axil_slave.sv
source/irq_prioritizer.sv
source/trap_dispatch.sv
source/csr_bank.sv
source/mtrap_unit.sv
bench/mtrap_unit_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = mtrap_unit_tb
FLIST     = flist.f
OBJ_DIR   = obj_dir
PASS_MSG  = === PASS ===

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
